/* hw/lsu_pkg.sv */
// Shared definitions for the load/store unit
//   size codes, funct3 encoding of loads and stores
//   mem_word_u, a memory word seen as bytes or as halfwords
//   MEM_WORDS_DEFAULT, default data memory depth in words

package lsu_pkg;

  // funct3 size codes
  localparam logic [2:0] LSU_SIZE_B  = 3'd0;
  localparam logic [2:0] LSU_SIZE_H  = 3'd1;
  localparam logic [2:0] LSU_SIZE_W  = 3'd2;
  localparam logic [2:0] LSU_SIZE_BU = 3'd4;
  localparam logic [2:0] LSU_SIZE_HU = 3'd5;

  // codes 3, 6 and 7 fall back to a word access

  // one 32-bit memory word, two views of the same bits
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } mem_word_u;

  // depth in 32-bit words, power of two
  localparam int unsigned MEM_WORDS_DEFAULT = 1024;

endpackage

/* hw/lsu_decode.sv */
// Request stage of the load/store unit
//   four-phase req/ack handshake with idle, busy and ack states
//   alignment check for halfword and word accesses
//   byte enables and store data placed on the byte lanes
//   one-cycle memory request pulse

`timescale 1ns/10ps

module lsu_decode #(
  parameter int unsigned MEM_WORDS = 1024
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [2:0]                   size_i,
  input  logic [31:0]                  addr_i,
  input  logic [31:0]                  wdata_i,
  input  logic                         done_i,
  output logic                         ack_o,
  output logic                         mem_req_o,
  output logic                         mem_we_o,
  output logic [3:0]                   mem_be_o,
  output logic [$clog2(MEM_WORDS)-1:0] mem_word_o,
  output logic [31:0]                  mem_wdata_o,
  output logic [2:0]                   op_size_o,
  output logic [1:0]                   op_offset_o,
  output logic                         op_load_o,
  output logic                         op_misaligned_o
);

  localparam int unsigned WORD_AW = $clog2(MEM_WORDS);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_BUSY = 2'd1;
  localparam logic [1:0] ST_ACK  = 2'd2;

  logic [1:0]         state_q;
  logic               we_q;
  logic [2:0]         size_q;
  logic [1:0]         offset_q;
  logic [WORD_AW-1:0] word_q;
  logic [31:0]        wdata_q;
  logic               misaligned;
  logic [3:0]         be_base;
  logic               accept;

  // only taken while idle and so never while ack_o is high
  assign accept = (state_q == ST_IDLE) && req_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      mem_req_o <= 1'b0;
    end else begin
      mem_req_o <= accept;
      case (state_q)
        ST_IDLE: if (req_i)   state_q <= ST_BUSY;
        ST_BUSY: if (done_i)  state_q <= ST_ACK;
        ST_ACK:  if (!req_i)  state_q <= ST_IDLE;
        default:              state_q <= ST_IDLE;
      endcase
    end
  end

  // request fields held until the next acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q     <= we_i;
      size_q   <= size_i;
      offset_q <= addr_i[1:0];
      word_q   <= addr_i[2 +: WORD_AW];
      wdata_q  <= wdata_i;
    end
  end

  // lane pattern at offset zero and store data replicated across lanes
  always_comb begin
    misaligned  = 1'b0;
    be_base     = 4'b1111;
    mem_wdata_o = wdata_q;
    case (size_q)
      lsu_pkg::LSU_SIZE_B, lsu_pkg::LSU_SIZE_BU: begin
        be_base     = 4'b0001;
        mem_wdata_o = {4{wdata_q[7:0]}};
      end
      lsu_pkg::LSU_SIZE_H, lsu_pkg::LSU_SIZE_HU: begin
        be_base     = 4'b0011;
        mem_wdata_o = {2{wdata_q[15:0]}};
        misaligned  = offset_q[0];
      end
      default: misaligned = (offset_q != 2'b00);
    endcase
  end

  assign mem_be_o        = (we_q && !misaligned) ? (be_base << offset_q) : 4'b0000;
  assign mem_we_o        = we_q;
  assign mem_word_o      = word_q;
  assign ack_o           = (state_q == ST_ACK);
  assign op_size_o       = size_q;
  assign op_offset_o     = offset_q;
  assign op_load_o       = !we_q;
  assign op_misaligned_o = misaligned;

  // enables only on a store and no lane lost off the top of the word
  a_be_only_on_store: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_req_o && mem_be_o != 4'b0000) |->
      (mem_we_o && $countones(mem_be_o) == $countones(be_base)));

endmodule

/* hw/data_mem.sv */
// Data memory of the load/store unit
//   word-addressed RAM, writes under per-byte enables
//   synchronous read port, output held between reads
//   one-cycle valid pulse after every request

`timescale 1ns/10ps

module data_mem #(
  parameter int unsigned MEM_WORDS = 1024
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         mem_req_i,
  input  logic                         mem_we_i,
  input  logic [3:0]                   mem_be_i,
  input  logic [$clog2(MEM_WORDS)-1:0] mem_word_i,
  input  logic [31:0]                  mem_wdata_i,
  output logic [31:0]                  mem_rdata_o,
  output logic                         mem_rvalid_o
);

  logic [31:0] ram [MEM_WORDS];

  // read port, a store leaves the last read word in place
  always_ff @(posedge clk_i) begin
    if (mem_req_i && !mem_we_i) begin
      mem_rdata_o <= ram[mem_word_i];
    end
  end

  // write port, one lane per enable bit
  always_ff @(posedge clk_i) begin
    if (mem_req_i && mem_we_i) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (mem_be_i[lane]) begin
          ram[mem_word_i][lane*8 +: 8] <= mem_wdata_i[lane*8 +: 8];
        end
      end
    end
  end

  // completion for reads and writes alike
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mem_rvalid_o <= 1'b0;
    end else begin
      mem_rvalid_o <= mem_req_i;
    end
  end

  // every valid pulse answers exactly one request
  a_rvalid_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rvalid_o |-> $past(mem_req_i) && !mem_req_i);

endmodule

/* hw/lsu_extend.sv */
// Result stage of the load/store unit
//   byte or halfword selection from the loaded word
//   sign extension for lb/lh, zero extension for lbu/lhu
//   zero result for stores and misaligned accesses
//   completion pulse back to the request stage

`timescale 1ns/10ps

module lsu_extend (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        mem_rvalid_i,
  input  logic [31:0] mem_rdata_i,
  input  logic [2:0]  op_size_i,
  input  logic [1:0]  op_offset_i,
  input  logic        op_load_i,
  input  logic        op_misaligned_i,
  output logic [31:0] rdata_o,
  output logic        misaligned_o,
  output logic        done_o
);

  lsu_pkg::mem_word_u word_view;
  logic [7:0]         sel_byte;
  logic [15:0]        sel_half;
  logic [31:0]        load_val;

  assign word_view = mem_rdata_i;

  always_comb begin
    sel_byte = word_view.bytes[op_offset_i];
    // halfword lane from offset bit 1, bit 0 is zero when aligned
    sel_half = word_view.halves[op_offset_i[1]];
    case (op_size_i)
      lsu_pkg::LSU_SIZE_B:  load_val = {{24{sel_byte[7]}}, sel_byte};
      lsu_pkg::LSU_SIZE_BU: load_val = {24'h000000, sel_byte};
      lsu_pkg::LSU_SIZE_H:  load_val = {{16{sel_half[15]}}, sel_half};
      lsu_pkg::LSU_SIZE_HU: load_val = {16'h0000, sel_half};
      default:              load_val = word_view;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_o      <= 32'h0000_0000;
      misaligned_o <= 1'b0;
      done_o       <= 1'b0;
    end else begin
      done_o <= mem_rvalid_i;
      if (mem_rvalid_i) begin
        rdata_o      <= (op_load_i && !op_misaligned_i) ? load_val : 32'h0000_0000;
        misaligned_o <= op_misaligned_i;
      end
    end
  end

endmodule

/* hw/lsu_top.sv */
// Load/store unit top level
//   decode stage with the external req/ack handshake
//   byte-enabled data memory
//   result stage with lane selection and extension

`timescale 1ns/10ps

module lsu_top #(
  parameter int unsigned MEM_WORDS = lsu_pkg::MEM_WORDS_DEFAULT
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [2:0]  size_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic        ack_o,
  output logic [31:0] rdata_o,
  output logic        misaligned_o
);

  localparam int unsigned WORD_AW = $clog2(MEM_WORDS);

  // decode to memory
  logic               mem_req;
  logic               mem_we;
  logic [3:0]         mem_be;
  logic [WORD_AW-1:0] mem_word;
  logic [31:0]        mem_wdata;

  // memory to result
  logic               mem_rvalid;
  logic [31:0]        mem_rdata;

  // held access attributes and completion
  logic [2:0]         op_size;
  logic [1:0]         op_offset;
  logic               op_load;
  logic               op_misaligned;
  logic               done;

  lsu_decode #(
    .MEM_WORDS (MEM_WORDS)
  ) i_lsu_decode (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_i           (req_i),
    .we_i            (we_i),
    .size_i          (size_i),
    .addr_i          (addr_i),
    .wdata_i         (wdata_i),
    .done_i          (done),
    .ack_o           (ack_o),
    .mem_req_o       (mem_req),
    .mem_we_o        (mem_we),
    .mem_be_o        (mem_be),
    .mem_word_o      (mem_word),
    .mem_wdata_o     (mem_wdata),
    .op_size_o       (op_size),
    .op_offset_o     (op_offset),
    .op_load_o       (op_load),
    .op_misaligned_o (op_misaligned)
  );

  data_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) i_data_mem (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .mem_req_i    (mem_req),
    .mem_we_i     (mem_we),
    .mem_be_i     (mem_be),
    .mem_word_i   (mem_word),
    .mem_wdata_i  (mem_wdata),
    .mem_rdata_o  (mem_rdata),
    .mem_rvalid_o (mem_rvalid)
  );

  lsu_extend i_lsu_extend (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .mem_rvalid_i    (mem_rvalid),
    .mem_rdata_i     (mem_rdata),
    .op_size_i       (op_size),
    .op_offset_i     (op_offset),
    .op_load_i       (op_load),
    .op_misaligned_i (op_misaligned),
    .rdata_o         (rdata_o),
    .misaligned_o    (misaligned_o),
    .done_o          (done)
  );

endmodule

/* sim/tb_clk_gen.sv */
// Testbench clock and reset
//   10 ns clock period
//   active-low reset held for the first two rising edges

`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // released just after the second edge
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

/* sim/tb_lsu_top.sv */
// Testbench for the load/store unit
//   table of accesses with expected rdata and misaligned flag
//   four-phase req/ack driver with ack latency checks
//   one line per row and a closing count line

`timescale 1ns/10ps

module tb_lsu_top;

  localparam int unsigned MEM_WORDS   = 256;
  localparam int          ACK_TIMEOUT = 20;
  // edges counted from the one that samples req_i
  localparam int          ACK_RISE_EDGES = 4;
  localparam int          ACK_FALL_EDGES = 1;

  logic        clk;
  logic        rst_n;
  logic        req_i;
  logic        we_i;
  logic [2:0]  size_i;
  logic [31:0] addr_i;
  logic [31:0] wdata_i;
  logic        ack_o;
  logic [31:0] rdata_o;
  logic        misaligned_o;

  // stimulus table with one entry per access
  bit          row_we[$];
  logic [2:0]  row_size[$];
  logic [31:0] row_addr[$];
  logic [31:0] row_wdata[$];
  logic [31:0] row_exp_rdata[$];
  bit          row_exp_mis[$];

  int error_count;
  int rows_run;
  int rows_failed;
  int reset_cycles;
  bit stop;
  bit row_ok;
  bit hung;

  tb_clk_gen i_tb_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  lsu_top #(
    .MEM_WORDS (MEM_WORDS)
  ) i_lsu_top (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (req_i),
    .we_i         (we_i),
    .size_i       (size_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .ack_o        (ack_o),
    .rdata_o      (rdata_o),
    .misaligned_o (misaligned_o)
  );

  task automatic add_row(
    input bit          we,
    input logic [2:0]  size,
    input logic [31:0] addr,
    input logic [31:0] wdata,
    input logic [31:0] exp_rdata,
    input bit          exp_mis
  );
    row_we.push_back(we);
    row_size.push_back(size);
    row_addr.push_back(addr);
    row_wdata.push_back(wdata);
    row_exp_rdata.push_back(exp_rdata);
    row_exp_mis.push_back(exp_mis);
  endtask

  task automatic build_table();
    // word store then load back
    add_row(1'b1, lsu_pkg::LSU_SIZE_W,  32'h010, 32'hdead_beef, 32'h0000_0000, 1'b0);
    add_row(1'b0, lsu_pkg::LSU_SIZE_W,  32'h010, 32'h0000_0000, 32'hdead_beef, 1'b0);
    // byte lanes of word 0x20 with bytes view 3..0 = c4 33 a2 11
    add_row(1'b1, lsu_pkg::LSU_SIZE_W,  32'h020, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(1'b1, lsu_pkg::LSU_SIZE_B,  32'h020, 32'hffff_ff11, 32'h0000_0000, 1'b0);
    add_row(1'b1, lsu_pkg::LSU_SIZE_B,  32'h021, 32'h1234_56a2, 32'h0000_0000, 1'b0);
    add_row(1'b1, lsu_pkg::LSU_SIZE_B,  32'h022, 32'h0000_0033, 32'h0000_0000, 1'b0);
    add_row(1'b1, lsu_pkg::LSU_SIZE_B,  32'h023, 32'h8888_88c4, 32'h0000_0000, 1'b0);
    add_row(1'b0, lsu_pkg::LSU_SIZE_W,  32'h020, 32'h0000_0000, 32'hc433_a211, 1'b0);
    // byte loads with the top bit set and clear
    add_row(1'b0, lsu_pkg::LSU_SIZE_B,  32'h021, 32'h0000_0000, 32'hffff_ffa2, 1'b0);
    add_row(1'b0, lsu_pkg::LSU_SIZE_BU, 32'h021, 32'h0000_0000, 32'h0000_00a2, 1'b0);
    add_row(1'b0, lsu_pkg::LSU_SIZE_B,  32'h022, 32'h0000_0000, 32'h0000_0033, 1'b0);
    add_row(1'b0, lsu_pkg::LSU_SIZE_BU, 32'h022, 32'h0000_0000, 32'h0000_0033, 1'b0);
    add_row(1'b0, lsu_pkg::LSU_SIZE_BU, 32'h023, 32'h0000_0000, 32'h0000_00c4, 1'b0);
    // halfword loads from halves view 1..0 = c433 a211
    add_row(1'b0, lsu_pkg::LSU_SIZE_H,  32'h020, 32'h0000_0000, 32'hffff_a211, 1'b0);
    add_row(1'b0, lsu_pkg::LSU_SIZE_HU, 32'h022, 32'h0000_0000, 32'h0000_c433, 1'b0);
    add_row(1'b1, lsu_pkg::LSU_SIZE_W,  32'h030, 32'h7f00_80ff, 32'h0000_0000, 1'b0);
    add_row(1'b0, lsu_pkg::LSU_SIZE_H,  32'h032, 32'h0000_0000, 32'h0000_7f00, 1'b0);
    add_row(1'b0, lsu_pkg::LSU_SIZE_HU, 32'h032, 32'h0000_0000, 32'h0000_7f00, 1'b0);
    add_row(1'b0, lsu_pkg::LSU_SIZE_HU, 32'h030, 32'h0000_0000, 32'h0000_80ff, 1'b0);
    add_row(1'b0, lsu_pkg::LSU_SIZE_H,  32'h030, 32'h0000_0000, 32'hffff_80ff, 1'b0);
    // misaligned stores must leave word 0x10 alone
    add_row(1'b1, lsu_pkg::LSU_SIZE_H,  32'h011, 32'h0000_aaaa, 32'h0000_0000, 1'b1);
    add_row(1'b1, lsu_pkg::LSU_SIZE_W,  32'h012, 32'h5555_5555, 32'h0000_0000, 1'b1);
    add_row(1'b0, lsu_pkg::LSU_SIZE_W,  32'h010, 32'h0000_0000, 32'hdead_beef, 1'b0);
    // misaligned loads
    add_row(1'b0, lsu_pkg::LSU_SIZE_H,  32'h023, 32'h0000_0000, 32'h0000_0000, 1'b1);
    add_row(1'b0, lsu_pkg::LSU_SIZE_W,  32'h021, 32'h0000_0000, 32'h0000_0000, 1'b1);
    // aligned half store into the upper lanes
    add_row(1'b1, lsu_pkg::LSU_SIZE_H,  32'h012, 32'h9999_1234, 32'h0000_0000, 1'b0);
    add_row(1'b0, lsu_pkg::LSU_SIZE_W,  32'h010, 32'h0000_0000, 32'h1234_beef, 1'b0);
  endtask

  // one access through the handshake with checks on ack
  task automatic run_access(input int idx, output bit ok, output bit timed_out);
    int rise_cycles;
    int fall_cycles;
    ok          = 1'b1;
    timed_out   = 1'b0;
    rise_cycles = 0;
    fall_cycles = 0;
    req_i   = 1'b1;
    we_i    = row_we[idx];
    size_i  = row_size[idx];
    addr_i  = row_addr[idx];
    wdata_i = row_wdata[idx];
    do begin
      @(posedge clk);
      #1;
      rise_cycles++;
    end while (!ack_o && rise_cycles < ACK_TIMEOUT);
    if (!ack_o) begin
      $display("row %0d: ack_o never rose within %0d cycles", idx, ACK_TIMEOUT);
      timed_out = 1'b1;
    end else begin
      if (rise_cycles != ACK_RISE_EDGES) begin
        $display("** Error row %0d: ack_o rise latency got %h expected %h",
                 idx, rise_cycles, ACK_RISE_EDGES);
        ok = 1'b0;
      end
      if (rdata_o !== row_exp_rdata[idx]) begin
        $display("** Error row %0d: rdata_o got %h expected %h",
                 idx, rdata_o, row_exp_rdata[idx]);
        ok = 1'b0;
      end
      if (misaligned_o !== row_exp_mis[idx]) begin
        $display("** Error row %0d: misaligned_o got %h expected %h",
                 idx, misaligned_o, row_exp_mis[idx]);
        ok = 1'b0;
      end
      req_i = 1'b0;
      do begin
        @(posedge clk);
        #1;
        fall_cycles++;
      end while (ack_o && fall_cycles < ACK_TIMEOUT);
      if (ack_o) begin
        $display("row %0d: ack_o stayed high after req_i dropped", idx);
        timed_out = 1'b1;
      end else if (fall_cycles != ACK_FALL_EDGES) begin
        $display("** Error row %0d: ack_o fall latency got %h expected %h",
                 idx, fall_cycles, ACK_FALL_EDGES);
        ok = 1'b0;
      end
    end
  endtask

  initial begin
    req_i        = 1'b0;
    we_i         = 1'b0;
    size_i       = 3'd0;
    addr_i       = 32'h0000_0000;
    wdata_i      = 32'h0000_0000;
    error_count  = 0;
    rows_run     = 0;
    rows_failed  = 0;
    reset_cycles = 0;
    stop         = 1'b0;
    build_table();

    // reset level as seen by the DUT at each edge
    do begin
      @(posedge clk);
      reset_cycles++;
    end while (!rst_n && reset_cycles < ACK_TIMEOUT);
    #1;
    if (!rst_n) begin
      $display("reset was never released");
      stop = 1'b1;
    end else if (ack_o !== 1'b0 || rdata_o !== 32'h0000_0000) begin
      $display("** Error reset: ack_o %h rdata_o %h expected 0 and 00000000", ack_o, rdata_o);
      error_count++;
    end

    for (int i = 0; i < row_we.size() && !stop; i++) begin
      run_access(i, row_ok, hung);
      rows_run++;
      if (!row_ok) error_count++;
      if (!row_ok || hung) rows_failed++;
      if (hung) stop = 1'b1;
      if (!hung) begin
        $display("row %0d: %s size %0d addr %h %s", i, row_we[i] ? "store" : "load ",
                 row_size[i], row_addr[i], row_ok ? "ok" : "failed");
      end
    end

    $display("rows run %0d of %0d, rows failed %0d, errors %0d",
             rows_run, row_we.size(), rows_failed, error_count);
    if (stop || error_count != 0 || rows_failed != 0) begin
      $display("CHECKS FAILED");
    end else begin
      $display("ALL CHECKS PASSED");
    end
    $finish;
  end

endmodule

/* lsu_top.f */
hw/lsu_pkg.sv
hw/lsu_decode.sv
hw/data_mem.sv
hw/lsu_extend.sv
hw/lsu_top.sv
sim/tb_clk_gen.sv
sim/tb_lsu_top.sv

/* Makefile */
# Verilator build and run of the load/store unit testbench

TOP := tb_lsu_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f lsu_top.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^ALL CHECKS PASSED$$"

clean:
	rm -rf obj_dir
